/* rtl/axi_mem_cfg.svh */
/*
  Build-time sizes of the AXI memory model. Data width must be a multiple of 32
  and the burst length a power of two. Address bits above the word index are ignored.
*/
`ifndef AXI_MEM_CFG_SVH
`define AXI_MEM_CFG_SVH

`define AXI_ID_WIDTH    4
`define AXI_ADDR_WIDTH  16
`define AXI_DATA_WIDTH  32
`define AXI_STRB_WIDTH  (`AXI_DATA_WIDTH / 8)
`define AXI_BURST_LEN   4
`define MEM_ELS         256

// -------------------- derived
`define MEM_IDX_WIDTH   $clog2(`MEM_ELS)
`define BYTE_OFS_WIDTH  $clog2(`AXI_STRB_WIDTH)
`define BURST_CNT_WIDTH ((`AXI_BURST_LEN > 1) ? $clog2(`AXI_BURST_LEN) : 1)

`endif

/* rtl/axi_mem_pkg.sv */
/*
  Types shared by the AXI memory model. Widths follow the config header
*/
`default_nettype none

package axi_mem_pkg;

  `include "axi_mem_cfg.svh"

  typedef logic [`AXI_ID_WIDTH-1:0]    axi_id_t;
  typedef logic [`AXI_ADDR_WIDTH-1:0]  axi_addr_t;
  typedef logic [`AXI_DATA_WIDTH-1:0]  axi_data_t;
  typedef logic [`AXI_STRB_WIDTH-1:0]  axi_strb_t;
  typedef logic [1:0]                  axi_resp_t; // Only OKAY is ever returned
  typedef logic [`MEM_IDX_WIDTH-1:0]   mem_idx_t;
  typedef logic [`BURST_CNT_WIDTH-1:0] burst_cnt_t;

  typedef enum logic [1:0] {
    WR_WAIT_ADDR,
    WR_WAIT_DATA,
    WR_RESP
  } wr_state_e;

  typedef enum logic {
    RD_WAIT_ADDR,
    RD_SEND_DATA
  } rd_state_e;

endpackage

`default_nettype wire

/* rtl/mem_port_if.sv */
/*
  Array port between the channel engines and the storage. No handshake:
  a write lands on the edge where wr_en is high, read data is combinational
*/
`timescale 1ns/10ps
`default_nettype none

interface mem_port_if;

  logic                  wr_en;
  axi_mem_pkg::mem_idx_t  wr_idx;
  axi_mem_pkg::axi_data_t wr_data;
  axi_mem_pkg::axi_strb_t wr_strb;

  axi_mem_pkg::mem_idx_t  rd_idx;
  axi_mem_pkg::axi_data_t rd_data;

  // Write engine side
  modport mem_wr (output wr_en, output wr_idx, output wr_data, output wr_strb);

  // Read engine side
  modport mem_rd (output rd_idx, input rd_data);

  // Storage side sees both ports
  modport mem (
    input  wr_en, input wr_idx, input wr_data, input wr_strb,
    input  rd_idx,
    output rd_data
  );

endinterface

`default_nettype wire

/* rtl/axi_mem_wr.sv */
/*
  Write channel engine. One transaction at a time, burst ends on wlast.
  awlen, size and burst type are ignored and bursts always increment
*/
`timescale 1ns/10ps
`default_nettype none

module axi_mem_wr (
  input  logic                   clk_i,
  input  logic                   reset_i,

  input  axi_mem_pkg::axi_id_t   awid_i,
  input  axi_mem_pkg::axi_addr_t awaddr_i,
  input  logic                   awvalid_i,
  output logic                   awready_o,

  input  axi_mem_pkg::axi_data_t wdata_i,
  input  axi_mem_pkg::axi_strb_t wstrb_i,
  input  logic                   wlast_i,
  input  logic                   wvalid_i,
  output logic                   wready_o,

  output axi_mem_pkg::axi_id_t   bid_o,
  output axi_mem_pkg::axi_resp_t bresp_o,
  output logic                   bvalid_o,
  input  logic                   bready_i,

  mem_port_if.mem_wr             mem_wr
);

  `include "axi_mem_cfg.svh"

  axi_mem_pkg::wr_state_e state_r, state_n;
  axi_mem_pkg::axi_id_t   awid_r;
  axi_mem_pkg::axi_addr_t awaddr_r;
  logic                   aw_fire;
  logic                   w_fire;

  assign awready_o = (state_r == axi_mem_pkg::WR_WAIT_ADDR);
  assign wready_o  = (state_r == axi_mem_pkg::WR_WAIT_DATA);
  assign bvalid_o  = (state_r == axi_mem_pkg::WR_RESP);
  assign bid_o     = awid_r;
  assign bresp_o   = '0;

  assign aw_fire = awvalid_i & awready_o;
  assign w_fire  = wvalid_i & wready_o;

  // -------------------- FSM
  always_comb begin
    state_n = state_r;
    case (state_r)
      axi_mem_pkg::WR_WAIT_ADDR: if (aw_fire) state_n = axi_mem_pkg::WR_WAIT_DATA;
      axi_mem_pkg::WR_WAIT_DATA: if (w_fire & wlast_i) state_n = axi_mem_pkg::WR_RESP;
      axi_mem_pkg::WR_RESP:      if (bready_i) state_n = axi_mem_pkg::WR_WAIT_ADDR;
      default:                   state_n = axi_mem_pkg::WR_WAIT_ADDR;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) state_r <= axi_mem_pkg::WR_WAIT_ADDR;
    else         state_r <= state_n;
  end

  // Address steps one word per accepted beat
  always_ff @(posedge clk_i) begin
    if (aw_fire) begin
      awid_r   <= awid_i;
      awaddr_r <= awaddr_i;
    end else if (w_fire) begin
      awaddr_r <= awaddr_r + axi_mem_pkg::axi_addr_t'(`AXI_STRB_WIDTH);
    end
  end

  // -------------------- array write port
  assign mem_wr.wr_en   = w_fire;
  assign mem_wr.wr_idx  = awaddr_r[`BYTE_OFS_WIDTH +: `MEM_IDX_WIDTH]; // Wraps modulo depth
  assign mem_wr.wr_data = wdata_i;
  assign mem_wr.wr_strb = wstrb_i;

endmodule

`default_nettype wire

/* rtl/axi_mem_rd.sv */
/*
  Read channel engine. Every burst is AXI_BURST_LEN incrementing beats,
  arlen is not looked at. Only one burst is in flight at a time
*/
`timescale 1ns/10ps
`default_nettype none

module axi_mem_rd (
  input  logic                   clk_i,
  input  logic                   reset_i,

  input  axi_mem_pkg::axi_id_t   arid_i,
  input  axi_mem_pkg::axi_addr_t araddr_i,
  input  logic                   arvalid_i,
  output logic                   arready_o,

  output axi_mem_pkg::axi_id_t   rid_o,
  output axi_mem_pkg::axi_data_t rdata_o,
  output axi_mem_pkg::axi_resp_t rresp_o,
  output logic                   rlast_o,
  output logic                   rvalid_o,
  input  logic                   rready_i,

  mem_port_if.mem_rd             mem_rd
);

  `include "axi_mem_cfg.svh"

  axi_mem_pkg::rd_state_e  state_r, state_n;
  axi_mem_pkg::axi_id_t    arid_r;
  axi_mem_pkg::axi_addr_t  araddr_r;
  axi_mem_pkg::burst_cnt_t cnt_r;
  logic                    ar_fire;
  logic                    r_fire;
  logic                    last_beat;

  assign arready_o = (state_r == axi_mem_pkg::RD_WAIT_ADDR);
  assign rvalid_o  = (state_r == axi_mem_pkg::RD_SEND_DATA);
  assign last_beat = (cnt_r == axi_mem_pkg::burst_cnt_t'(`AXI_BURST_LEN - 1));
  assign rlast_o   = rvalid_o & last_beat;
  assign rid_o     = arid_r;
  assign rresp_o   = '0;

  assign ar_fire = arvalid_i & arready_o;
  assign r_fire  = rvalid_o & rready_i;

  // -------------------- FSM
  always_comb begin
    state_n = state_r;
    case (state_r)
      axi_mem_pkg::RD_WAIT_ADDR: if (ar_fire) state_n = axi_mem_pkg::RD_SEND_DATA;
      axi_mem_pkg::RD_SEND_DATA: if (r_fire & last_beat) state_n = axi_mem_pkg::RD_WAIT_ADDR;
      default:                   state_n = axi_mem_pkg::RD_WAIT_ADDR;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_r <= axi_mem_pkg::RD_WAIT_ADDR;
      cnt_r   <= '0;
    end else begin
      state_r <= state_n;
      if (ar_fire)     cnt_r <= '0;
      else if (r_fire) cnt_r <= cnt_r + 1'b1;
    end
  end

  // Beat address; held while R is stalled so the beat stays put
  always_ff @(posedge clk_i) begin
    if (ar_fire) begin
      arid_r   <= arid_i;
      araddr_r <= araddr_i;
    end else if (r_fire) begin
      araddr_r <= araddr_r + axi_mem_pkg::axi_addr_t'(`AXI_STRB_WIDTH);
    end
  end

  // -------------------- array read port
  assign mem_rd.rd_idx = araddr_r[`BYTE_OFS_WIDTH +: `MEM_IDX_WIDTH];
  assign rdata_o       = mem_rd.rd_data;

endmodule

`default_nettype wire

/* rtl/axi_mem_array.sv */
/*
  Word storage with byte strobes. Words never written read back as repeated
  32'hdeadbeef. A partial write marks the whole word as written.
  A read in the same cycle as a write to that word sees the old contents
*/
`timescale 1ns/10ps
`default_nettype none

module axi_mem_array (
  input  logic   clk_i,
  input  logic   reset_i,
  mem_port_if.mem mem
);

  `include "axi_mem_cfg.svh"

  localparam axi_mem_pkg::axi_data_t FILL_WORD = {(`AXI_DATA_WIDTH / 32){32'hdeadbeef}};

  axi_mem_pkg::axi_data_t ram [`MEM_ELS];
  logic [`MEM_ELS-1:0]    written_r;

  // -------------------- write
  always_ff @(posedge clk_i) begin
    if (mem.wr_en) begin
      for (int i = 0; i < `AXI_STRB_WIDTH; i++) begin
        if (mem.wr_strb[i]) ram[mem.wr_idx][i*8 +: 8] <= mem.wr_data[i*8 +: 8];
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i)         written_r <= '0;
    else if (mem.wr_en)  written_r[mem.wr_idx] <= 1'b1;
  end

  // -------------------- read
  assign mem.rd_data = written_r[mem.rd_idx] ? ram[mem.rd_idx] : FILL_WORD;

endmodule

`default_nettype wire

/* rtl/axi_mem.sv */
/*
  Simulation AXI memory slave on a subset of AXI. Single outstanding
  transaction per channel, responses always OKAY, no protection or cache
  signals. Sizes come from the config header
*/
`timescale 1ns/10ps
`default_nettype none

module axi_mem (
  input  logic                   clk_i,
  input  logic                   reset_i,

  // Write address
  input  axi_mem_pkg::axi_id_t   awid_i,
  input  axi_mem_pkg::axi_addr_t awaddr_i,
  input  logic                   awvalid_i,
  output logic                   awready_o,

  // Write data
  input  axi_mem_pkg::axi_data_t wdata_i,
  input  axi_mem_pkg::axi_strb_t wstrb_i,
  input  logic                   wlast_i,
  input  logic                   wvalid_i,
  output logic                   wready_o,

  // Write response
  output axi_mem_pkg::axi_id_t   bid_o,
  output axi_mem_pkg::axi_resp_t bresp_o,
  output logic                   bvalid_o,
  input  logic                   bready_i,

  // Read address
  input  axi_mem_pkg::axi_id_t   arid_i,
  input  axi_mem_pkg::axi_addr_t araddr_i,
  input  logic                   arvalid_i,
  output logic                   arready_o,

  // Read data
  output axi_mem_pkg::axi_id_t   rid_o,
  output axi_mem_pkg::axi_data_t rdata_o,
  output axi_mem_pkg::axi_resp_t rresp_o,
  output logic                   rlast_o,
  output logic                   rvalid_o,
  input  logic                   rready_i
);

  mem_port_if i_port ();

  axi_mem_wr i_wr (
    .clk_i     (clk_i),
    .reset_i   (reset_i),
    .awid_i    (awid_i),
    .awaddr_i  (awaddr_i),
    .awvalid_i (awvalid_i),
    .awready_o (awready_o),
    .wdata_i   (wdata_i),
    .wstrb_i   (wstrb_i),
    .wlast_i   (wlast_i),
    .wvalid_i  (wvalid_i),
    .wready_o  (wready_o),
    .bid_o     (bid_o),
    .bresp_o   (bresp_o),
    .bvalid_o  (bvalid_o),
    .bready_i  (bready_i),
    .mem_wr    (i_port.mem_wr)
  );

  axi_mem_rd i_rd (
    .clk_i     (clk_i),
    .reset_i   (reset_i),
    .arid_i    (arid_i),
    .araddr_i  (araddr_i),
    .arvalid_i (arvalid_i),
    .arready_o (arready_o),
    .rid_o     (rid_o),
    .rdata_o   (rdata_o),
    .rresp_o   (rresp_o),
    .rlast_o   (rlast_o),
    .rvalid_o  (rvalid_o),
    .rready_i  (rready_i),
    .mem_rd    (i_port.mem_rd)
  );

  axi_mem_array i_array (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .mem     (i_port.mem)
  );

endmodule

`default_nettype wire

/* testbench/tb_clock_gen.sv */
/*
  Free-running 8 ns clock. Reset is high over the first four rising edges
  and drops on a falling edge
*/
`timescale 1ns/10ps
`default_nettype none

module tb_clock_gen (
  output logic clk_o,
  output logic reset_o
);

  initial begin
    clk_o   = 1'b0;
    reset_o = 1'b1;
    repeat (4) @(negedge clk_o);
    reset_o = 1'b0;
  end

  always #4 clk_o = ~clk_o;

endmodule

`default_nettype wire

/* testbench/axi_mem_props.sv */
/*
  Handshake rules of the AXI memory model, bound to its top level.
  Engine states are decoded from the channel outputs. The rdata rule
  assumes no write lands on the word being read during an R stall
*/
`timescale 1ns/10ps
`default_nettype none

module axi_mem_props (
  input  logic                   clk_i,
  input  logic                   reset_i,
  input  logic                   awready_i,
  input  logic                   wready_i,
  input  logic                   bvalid_i,
  input  logic                   bready_i,
  input  axi_mem_pkg::axi_id_t   bid_i,
  input  logic                   arready_i,
  input  logic                   rvalid_i,
  input  logic                   rready_i,
  input  axi_mem_pkg::axi_data_t rdata_i,
  input  axi_mem_pkg::axi_id_t   rid_i,
  input  logic                   rlast_i
);

  axi_mem_pkg::wr_state_e wr_state;
  axi_mem_pkg::rd_state_e rd_state;

  always_comb begin
    if (bvalid_i)      wr_state = axi_mem_pkg::WR_RESP;
    else if (wready_i) wr_state = axi_mem_pkg::WR_WAIT_DATA;
    else               wr_state = axi_mem_pkg::WR_WAIT_ADDR;
  end

  assign rd_state = rvalid_i ? axi_mem_pkg::RD_SEND_DATA : axi_mem_pkg::RD_WAIT_ADDR;

  // -------------------- write side
  a_wr_one_state: assert property (@(posedge clk_i) disable iff (reset_i)
    $onehot({awready_i, wready_i, bvalid_i}))
    else $error("awready, wready and bvalid are not one-hot");

  a_b_hold: assert property (@(posedge clk_i) disable iff (reset_i)
    (wr_state == axi_mem_pkg::WR_RESP) && !bready_i
      |=> (wr_state == axi_mem_pkg::WR_RESP) && $stable(bid_i))
    else $error("B response changed before bready");

  // -------------------- read side
  a_r_hold: assert property (@(posedge clk_i) disable iff (reset_i)
    (rd_state == axi_mem_pkg::RD_SEND_DATA) && !rready_i
      |=> rvalid_i && $stable(rdata_i) && $stable(rid_i) && $stable(rlast_i))
    else $error("R beat changed before rready");

  a_ar_busy: assert property (@(posedge clk_i) disable iff (reset_i)
    (rd_state == axi_mem_pkg::RD_SEND_DATA) |-> !arready_i)
    else $error("arready high during a read burst");

  a_rlast_valid: assert property (@(posedge clk_i) disable iff (reset_i)
    rlast_i |-> rvalid_i)
    else $error("rlast high without rvalid");

endmodule

bind axi_mem axi_mem_props i_props (
  .clk_i     (clk_i),
  .reset_i   (reset_i),
  .awready_i (awready_o),
  .wready_i  (wready_o),
  .bvalid_i  (bvalid_o),
  .bready_i  (bready_i),
  .bid_i     (bid_o),
  .arready_i (arready_o),
  .rvalid_i  (rvalid_o),
  .rready_i  (rready_i),
  .rdata_i   (rdata_o),
  .rid_i     (rid_o),
  .rlast_i   (rlast_o)
);

`default_nettype wire

/* testbench/axi_mem_tb.sv */
/*
  Directed tests for the AXI memory model. One transaction at a time per channel.
  Reads are predicted from a byte-wide reference memory with its own written flags.
  Partial strobes are only used on words that were fully written before
*/
`timescale 1ns/10ps
`default_nettype none

module axi_mem_tb;

  `include "axi_mem_cfg.svh"

  // Beats over all tests, sizes the timeout
  localparam int TOTAL_BEATS = 49;
  localparam int CYCLE_LIMIT = 10 * TOTAL_BEATS + 100;

  logic                   clk;
  logic                   reset;
  axi_mem_pkg::axi_id_t   awid;
  axi_mem_pkg::axi_addr_t awaddr;
  logic                   awvalid;
  logic                   awready;
  axi_mem_pkg::axi_data_t wdata;
  axi_mem_pkg::axi_strb_t wstrb;
  logic                   wlast;
  logic                   wvalid;
  logic                   wready;
  axi_mem_pkg::axi_id_t   bid;
  axi_mem_pkg::axi_resp_t bresp;
  logic                   bvalid;
  logic                   bready;
  axi_mem_pkg::axi_id_t   arid;
  axi_mem_pkg::axi_addr_t araddr;
  logic                   arvalid;
  logic                   arready;
  axi_mem_pkg::axi_id_t   rid;
  axi_mem_pkg::axi_data_t rdata;
  axi_mem_pkg::axi_resp_t rresp;
  logic                   rlast;
  logic                   rvalid;
  logic                   rready;

  logic [7:0]  ref_bytes [`MEM_ELS][`AXI_STRB_WIDTH];
  logic        ref_written [`MEM_ELS];
  logic [15:0] lfsr_state;
  int          cycles = 0;

  tb_clock_gen i_clk (.clk_o(clk), .reset_o(reset));

  axi_mem i_dut (
    .clk_i(clk), .reset_i(reset),
    .awid_i(awid), .awaddr_i(awaddr), .awvalid_i(awvalid), .awready_o(awready),
    .wdata_i(wdata), .wstrb_i(wstrb), .wlast_i(wlast), .wvalid_i(wvalid), .wready_o(wready),
    .bid_o(bid), .bresp_o(bresp), .bvalid_o(bvalid), .bready_i(bready),
    .arid_i(arid), .araddr_i(araddr), .arvalid_i(arvalid), .arready_o(arready),
    .rid_o(rid), .rdata_o(rdata), .rresp_o(rresp), .rlast_o(rlast), .rvalid_o(rvalid),
    .rready_i(rready)
  );

  // -------------------- helpers
  task automatic stop_with_error(input string line);
    $display("%s", line);
    $display("SIMULATION FAILED");
    $fatal(1);
  endtask

  task automatic check_data(input axi_mem_pkg::axi_data_t got, input axi_mem_pkg::axi_data_t exp,
                            input string what);
    if (got !== exp)
      stop_with_error($sformatf("Fail at %0t ns: %s got %h, expected %h", $time, what, got, exp));
  endtask

  task automatic check_id(input axi_mem_pkg::axi_id_t got, input axi_mem_pkg::axi_id_t exp,
                          input string what);
    if (got !== exp)
      stop_with_error($sformatf("Fail at %0t ns: %s got %h, expected %h", $time, what, got, exp));
  endtask

  task automatic check_resp(input axi_mem_pkg::axi_resp_t got,
                            input axi_mem_pkg::axi_resp_t exp, input string what);
    if (got !== exp)
      stop_with_error($sformatf("Fail at %0t ns: %s got %h, expected %h", $time, what, got, exp));
  endtask

  task automatic check_flag(input logic got, input logic exp, input string what);
    if (got !== exp)
      stop_with_error($sformatf("Fail at %0t ns: %s got %b, expected %b", $time, what, got, exp));
  endtask

  // Galois LFSR, x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic lfsr_bit();
    logic out;
    out        = lfsr_state[0];
    lfsr_state = {1'b0, lfsr_state[15:1]} ^ (out ? 16'hb400 : 16'h0000);
    return out;
  endfunction

  function automatic axi_mem_pkg::axi_data_t rand_word();
    axi_mem_pkg::axi_data_t w;
    for (int i = 0; i < `AXI_DATA_WIDTH; i++) w[i] = lfsr_bit();
    return w;
  endfunction

  // Word index of a beat, modulo the depth
  function automatic axi_mem_pkg::mem_idx_t word_index(input axi_mem_pkg::axi_addr_t addr,
                                                       input int beat);
    return axi_mem_pkg::mem_idx_t'(int'(addr >> `BYTE_OFS_WIDTH) + beat);
  endfunction

  function automatic axi_mem_pkg::axi_data_t expect_word(input axi_mem_pkg::mem_idx_t idx);
    axi_mem_pkg::axi_data_t w;
    w = {(`AXI_DATA_WIDTH / 32){32'hdeadbeef}};
    if (ref_written[idx]) begin
      for (int i = 0; i < `AXI_STRB_WIDTH; i++) w[i*8 +: 8] = ref_bytes[idx][i];
    end
    return w;
  endfunction

  // -------------------- bus tasks, entered and left on a falling edge
  task automatic axi_write_burst(input axi_mem_pkg::axi_id_t id,
                                 input axi_mem_pkg::axi_addr_t addr, input int beats,
                                 input axi_mem_pkg::axi_strb_t strb, input logic stall);
    axi_mem_pkg::axi_data_t data;
    axi_mem_pkg::mem_idx_t  idx;
    logic                   b_seen;
    logic                   b_done;
    awid    = id;
    awaddr  = addr;
    awvalid = 1'b1;
    while (!awready) @(negedge clk);
    @(negedge clk);
    awvalid = 1'b0;
    for (int b = 0; b < beats; b++) begin
      data   = rand_word();
      wdata  = data;
      wstrb  = strb;
      wlast  = (b == beats - 1);
      wvalid = 1'b1;
      while (!wready) @(negedge clk);
      idx = word_index(addr, b);
      for (int i = 0; i < `AXI_STRB_WIDTH; i++) begin
        if (strb[i]) ref_bytes[idx][i] = data[i*8 +: 8];
      end
      ref_written[idx] = 1'b1;
      @(negedge clk);
    end
    wvalid = 1'b0;
    wlast  = 1'b0;
    b_seen = 1'b0;
    b_done = 1'b0;
    while (!b_done) begin
      bready = stall ? lfsr_bit() : 1'b1;
      if (b_seen) check_flag(bvalid, 1'b1, "bvalid held until bready");
      if (bvalid && bready) begin
        check_id(bid, id, "bid");
        check_resp(bresp, '0, "bresp");
        b_done = 1'b1;
      end
      b_seen = bvalid;
      @(negedge clk);
    end
    bready = 1'b0;
  endtask

  task automatic axi_read_burst(input axi_mem_pkg::axi_id_t id,
                                input axi_mem_pkg::axi_addr_t addr, input logic stall);
    int beat;
    arid    = id;
    araddr  = addr;
    arvalid = 1'b1;
    while (!arready) @(negedge clk);
    @(negedge clk);
    arvalid = 1'b0;
    beat    = 0;
    while (beat < `AXI_BURST_LEN) begin
      rready = stall ? lfsr_bit() : 1'b1;
      if (rvalid && rready) begin
        check_data(rdata, expect_word(word_index(addr, beat)), $sformatf("rdata beat %0d", beat));
        check_id(rid, id, "rid");
        check_resp(rresp, '0, "rresp");
        check_flag(rlast, beat == `AXI_BURST_LEN - 1, $sformatf("rlast beat %0d", beat));
        beat++;
      end
      @(negedge clk);
    end
    rready = 1'b0;
  endtask

  // -------------------- tests
  task automatic verify_reset_outputs();
    check_flag(awready, 1'b1, "awready after reset");
    check_flag(arready, 1'b1, "arready after reset");
    check_flag(bvalid, 1'b0, "bvalid after reset");
    check_flag(rvalid, 1'b0, "rvalid after reset");
    check_flag(wready, 1'b0, "wready after reset");
    check_flag(rlast, 1'b0, "rlast after reset");
  endtask

  task automatic write_then_read_back();
    axi_write_burst(4'h3, 16'h0040, 4, '1, 1'b0);
    axi_read_burst(4'h5, 16'h0040, 1'b0);
  endtask

  task automatic merge_partial_strobes();
    axi_write_burst(4'h1, 16'h0040, 4, 4'b0101, 1'b0); // Same words as the full write
    axi_read_burst(4'h6, 16'h0040, 1'b0);
  endtask

  task automatic read_unwritten_fill();
    axi_read_burst(4'h2, 16'h0200, 1'b0);
    axi_write_burst(4'h8, 16'h0300, 1, '1, 1'b0);
    axi_read_burst(4'h9, 16'h0300, 1'b0); // One stored word, then fill
  endtask

  task automatic run_under_backpressure();
    axi_write_burst(4'h7, 16'h0100, 4, '1, 1'b1);
    axi_read_burst(4'h2, 16'h0100, 1'b1);
    axi_write_burst(4'h9, 16'h0104, 4, '1, 1'b1);
    axi_read_burst(4'h4, 16'h0104, 1'b1);
  endtask

  task automatic wrap_high_address();
    axi_write_burst(4'ha, 16'h0410, 4, '1, 1'b0); // Word 260 aliases word 4
    axi_read_burst(4'hb, 16'h0010, 1'b0);
  endtask

  // -------------------- timeout
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= CYCLE_LIMIT)
      stop_with_error($sformatf("Timeout after %0d cycles, a handshake never completed",
                                cycles));
  end

  initial begin
    lfsr_state = 16'd71;
    awid       = '0;
    awaddr     = '0;
    awvalid    = 1'b0;
    wdata      = '0;
    wstrb      = '0;
    wlast      = 1'b0;
    wvalid     = 1'b0;
    bready     = 1'b0;
    arid       = '0;
    araddr     = '0;
    arvalid    = 1'b0;
    rready     = 1'b0;
    for (int i = 0; i < `MEM_ELS; i++) ref_written[i] = 1'b0;
    @(negedge clk);
    while (reset) @(negedge clk);
    verify_reset_outputs();
    write_then_read_back();
    merge_partial_strobes();
    read_unwritten_fill();
    run_under_backpressure();
    wrap_high_address();
    $display("SIMULATION PASSED");
    $finish;
  end

endmodule

`default_nettype wire

/* vlog.f */
+incdir+rtl
rtl/axi_mem_pkg.sv
rtl/mem_port_if.sv
rtl/axi_mem_wr.sv
rtl/axi_mem_rd.sv
rtl/axi_mem_array.sv
rtl/axi_mem.sv
testbench/tb_clock_gen.sv
testbench/axi_mem_props.sv
testbench/axi_mem_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build with Verilator, run, and decide the result from the simulation log
rm -f sim.log
verilator --binary --timing --assert -f vlog.f --top-module axi_mem_tb -o axi_mem_sim \
  || { echo "Build failed"; exit 1; }
./obj_dir/axi_mem_sim > sim.log 2>&1
cat sim.log
grep -qx "SIMULATION PASSED" sim.log && echo "Result: pass" \
  || { echo "Result: fail"; exit 1; }
